// File: hdl/radio_pkg.sv
`default_nettype none

package radio_pkg;

  // **************************************************
  // Radio array and capture word layout
  // **************************************************

  localparam int RADIOS = 24;  // One I bit and one Q bit per radio each sample.
  localparam int LANE_BITS = 8;
  localparam int SAMPLE_BITS = 2 * RADIOS;
  localparam int SAMPLE_BYTES = (SAMPLE_BITS + LANE_BITS - 1) / LANE_BITS;
  localparam int TAGGED_BITS = SAMPLE_BITS + 1;  // Sample word plus frame-end tag.

  typedef struct packed {
    logic [RADIOS-1:0] q;  // Upper half of the word.
    logic [RADIOS-1:0] i;
  } iq_pair_t;

  // Lane 0 holds I bits 7..0 and lane 5 holds Q bits 23..16.
  typedef union packed {
    iq_pair_t iq;
    logic [SAMPLE_BYTES-1:0][LANE_BITS-1:0] bytes;
  } sample_word_u;

endpackage

`default_nettype wire

// File: hdl/stream_pkg.sv
`default_nettype none

package stream_pkg;

  // **************************************************
  // Byte stream between splitter, buffer and output
  // **************************************************

  localparam int BYTE_BITS = 8;

  typedef logic [BYTE_BITS-1:0] raw_byte_t;  // One byte of the raw capture stream.

endpackage

`default_nettype wire

// File: hdl/axis_afifo.sv
`default_nettype none

module axis_afifo #(
  parameter int WIDTH = 49,
  parameter int ABITS = 4
) (
  input  wire              s_clock_i,
  input  wire              m_clock_i,
  input  wire              rst_n_i,

  input  wire              s_valid_i,
  input  wire [WIDTH-1:0]  s_data_i,

  output logic             m_valid_o,
  input  wire              m_ready_i,
  output logic [WIDTH-1:0] m_data_o
);

  localparam int DEPTH = 2 ** ABITS;

  function automatic logic [ABITS:0] bin2gray(input logic [ABITS:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  logic [WIDTH-1:0] mem [DEPTH];

  logic [1:0]     s_rst_q;
  logic [1:0]     m_rst_q;
  logic           s_rst_n;
  logic           m_rst_n;

  logic [ABITS:0] wbin_q;
  logic [ABITS:0] wgray_q;
  logic [ABITS:0] rbin_q;
  logic [ABITS:0] rgray_q;
  logic [ABITS:0] rgray_s1_q;
  logic [ABITS:0] rgray_s2_q;
  logic [ABITS:0] wgray_s1_q;
  logic [ABITS:0] wgray_s2_q;

  logic           full;
  logic           wr_en;
  logic           rd_en;

  // **************************************************
  // Reset release, one synchroniser per clock domain
  // **************************************************

  always_ff @(posedge s_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s_rst_q <= '0;
    end else begin
      s_rst_q <= {s_rst_q[0], 1'b1};
    end
  end

  always_ff @(posedge m_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      m_rst_q <= '0;
    end else begin
      m_rst_q <= {m_rst_q[0], 1'b1};
    end
  end

  assign s_rst_n = s_rst_q[1];
  assign m_rst_n = m_rst_q[1];

  // **************************************************
  // Write side, sig_clock domain
  // **************************************************

  // Full when the pointers differ only in their two top Gray bits.
  assign full  = (wgray_q == {~rgray_s2_q[ABITS:ABITS-1], rgray_s2_q[ABITS-2:0]});
  assign wr_en = s_valid_i && !full;  // A word offered while full is lost.

  always_ff @(posedge s_clock_i) begin
    if (wr_en) begin
      mem[wbin_q[ABITS-1:0]] <= s_data_i;
    end
  end

  always_ff @(posedge s_clock_i or negedge s_rst_n) begin
    if (!s_rst_n) begin
      wbin_q  <= '0;
      wgray_q <= '0;
    end else if (wr_en) begin
      wbin_q  <= wbin_q + 1'b1;
      wgray_q <= bin2gray(wbin_q + 1'b1);
    end
  end

  always_ff @(posedge s_clock_i or negedge s_rst_n) begin
    if (!s_rst_n) begin
      rgray_s1_q <= '0;
      rgray_s2_q <= '0;
    end else begin
      rgray_s1_q <= rgray_q;
      rgray_s2_q <= rgray_s1_q;
    end
  end

  // **************************************************
  // Read side, bus_clock domain
  // **************************************************

  assign m_valid_o = (rgray_q != wgray_s2_q);
  assign m_data_o  = mem[rbin_q[ABITS-1:0]];  // Stable once the pointer has crossed.
  assign rd_en     = m_valid_o && m_ready_i;

  always_ff @(posedge m_clock_i or negedge m_rst_n) begin
    if (!m_rst_n) begin
      rbin_q  <= '0;
      rgray_q <= '0;
    end else if (rd_en) begin
      rbin_q  <= rbin_q + 1'b1;
      rgray_q <= bin2gray(rbin_q + 1'b1);
    end
  end

  always_ff @(posedge m_clock_i or negedge m_rst_n) begin
    if (!m_rst_n) begin
      wgray_s1_q <= '0;
      wgray_s2_q <= '0;
    end else begin
      wgray_s1_q <= wgray_q;
      wgray_s2_q <= wgray_s1_q;
    end
  end

endmodule

`default_nettype wire

// File: hdl/axis_adapter.sv
`default_nettype none

module axis_adapter
  import radio_pkg::*, stream_pkg::*;
(
  input  wire               clock_i,
  input  wire               rst_n_i,

  input  wire               s_valid_i,
  output logic              s_ready_o,
  input  wire sample_word_u s_word_i,
  input  wire               s_end_i,

  output logic              m_valid_o,
  input  wire               m_ready_i,
  output raw_byte_t         m_data_o,
  output logic              m_end_o
);

  localparam int LW = $clog2(SAMPLE_BYTES);
  localparam logic [LW-1:0] LANE_LAST = LW'(SAMPLE_BYTES - 1);

  sample_word_u  word_q;
  logic          end_q;
  logic          full_q;
  logic [LW-1:0] lane_q;
  logic          last_lane;
  logic          load;

  assign last_lane = (lane_q == LANE_LAST);

  // A new word is taken as the final lane of the held word leaves.
  assign s_ready_o = !full_q || (m_ready_i && last_lane);
  assign load      = s_valid_i && s_ready_o;

  assign m_valid_o = full_q;
  assign m_data_o  = word_q.bytes[lane_q];  // Low lane first.
  assign m_end_o   = end_q && last_lane;

  always_ff @(posedge clock_i) begin
    if (load) begin
      word_q <= s_word_i;
      end_q  <= s_end_i;
    end
  end

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else if (load) begin
      full_q <= 1'b1;
      lane_q <= '0;
    end else if (full_q && m_ready_i) begin
      if (last_lane) begin
        full_q <= 1'b0;  // Word drained and nothing waiting.
        lane_q <= '0;
      end else begin
        lane_q <= lane_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/packet_fifo.sv
`default_nettype none

module packet_fifo
  import stream_pkg::*;
#(
  parameter int DEPTH      = 2048,
  parameter int MAX_LENGTH = 512
) (
  input  wire            clock_i,
  input  wire            rst_n_i,

  input  wire            s_valid_i,
  output logic           s_ready_o,
  input  wire raw_byte_t s_data_i,
  input  wire            s_end_i,

  output logic           m_valid_o,
  input  wire            m_ready_i,
  output logic           m_last_o,
  output raw_byte_t      m_data_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int LW = $clog2(MAX_LENGTH + 1);
  localparam logic [LW-1:0] LEN_LAST = LW'(MAX_LENGTH - 1);

  raw_byte_t     data_mem [DEPTH];
  logic          end_mem  [DEPTH];

  logic [AW:0]   wr_ptr_q;
  logic [AW:0]   cm_ptr_q;
  logic [AW:0]   rd_ptr_q;
  logic [LW-1:0] len_q;

  logic          wr_en;
  logic          wr_end;
  logic          rd_en;

  // **************************************************
  // Write and commit
  // **************************************************

  // Full when the pointers match in address but not in wrap bit.
  assign s_ready_o = (wr_ptr_q[AW] == rd_ptr_q[AW]) ||
                     (wr_ptr_q[AW-1:0] != rd_ptr_q[AW-1:0]);
  assign wr_en     = s_valid_i && s_ready_o;
  assign wr_end    = s_end_i || (len_q == LEN_LAST);  // Frame end or full chunk.

  always_ff @(posedge clock_i) begin
    if (wr_en) begin
      data_mem[wr_ptr_q[AW-1:0]] <= s_data_i;
      end_mem[wr_ptr_q[AW-1:0]]  <= wr_end;
    end
  end

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      cm_ptr_q <= '0;
      len_q    <= '0;
    end else if (wr_en) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
      if (wr_end) begin
        cm_ptr_q <= wr_ptr_q + 1'b1;  // Whole packet now visible to the reader.
        len_q    <= '0;
      end else begin
        len_q    <= len_q + 1'b1;
      end
    end
  end

  // **************************************************
  // Read and output register
  // **************************************************

  // Refill whenever the output register is empty or being taken.
  assign rd_en = (cm_ptr_q != rd_ptr_q) && (!m_valid_o || m_ready_i);

  always_ff @(posedge clock_i) begin
    if (rd_en) begin
      m_data_o <= data_mem[rd_ptr_q[AW-1:0]];
    end
  end

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q  <= '0;
      m_valid_o <= 1'b0;
      m_last_o  <= 1'b0;
    end else if (rd_en) begin
      rd_ptr_q  <= rd_ptr_q + 1'b1;
      m_valid_o <= 1'b1;
      m_last_o  <= end_mem[rd_ptr_q[AW-1:0]];
    end else if (m_ready_i) begin
      m_valid_o <= 1'b0;
      m_last_o  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/acquire.sv
`default_nettype none

module acquire
  import radio_pkg::*, stream_pkg::*;
#(
  parameter int CHUNK       = 512,
  parameter int SRAM_BYTES  = 2048,
  parameter int AFIFO_ABITS = 4
) (
  input  wire              sig_clock,
  input  wire              bus_clock,
  input  wire              rst_n_i,

  // Raw one-bit radio samples.
  input  wire              sig_valid_i,
  input  wire              sig_last_i,
  input  wire [RADIOS-1:0] sig_idata_i,
  input  wire [RADIOS-1:0] sig_qdata_i,

  // Byte stream of captured samples.
  output logic             raw_tvalid_o,
  input  wire              raw_tready_i,
  output logic             raw_tlast_o,
  output raw_byte_t        raw_tdata_o
);

  sample_word_u           sig_word;
  sample_word_u           word_sample;
  logic [TAGGED_BITS-1:0] word_data;
  logic                   word_valid;
  logic                   word_ready;
  logic                   word_end;

  raw_byte_t              byte_data;
  logic                   byte_valid;
  logic                   byte_ready;
  logic                   byte_end;

  assign sig_word.iq = iq_pair_t'{q: sig_qdata_i, i: sig_idata_i};

  axis_afifo #(
    .WIDTH(TAGGED_BITS),
    .ABITS(AFIFO_ABITS)
  ) i_afifo (
    .s_clock_i(sig_clock),
    .m_clock_i(bus_clock),
    .rst_n_i  (rst_n_i),
    .s_valid_i(sig_valid_i),
    .s_data_i ({sig_last_i, sig_word}),  // Frame-end tag rides above the word.
    .m_valid_o(word_valid),
    .m_ready_i(word_ready),
    .m_data_o (word_data)
  );

  assign word_end    = word_data[TAGGED_BITS-1];
  assign word_sample = word_data[SAMPLE_BITS-1:0];

  axis_adapter i_adapter (
    .clock_i  (bus_clock),
    .rst_n_i  (rst_n_i),
    .s_valid_i(word_valid),
    .s_ready_o(word_ready),
    .s_word_i (word_sample),
    .s_end_i  (word_end),
    .m_valid_o(byte_valid),
    .m_ready_i(byte_ready),
    .m_data_o (byte_data),
    .m_end_o  (byte_end)
  );

  packet_fifo #(
    .DEPTH     (SRAM_BYTES),
    .MAX_LENGTH(CHUNK)
  ) i_packet_fifo (
    .clock_i  (bus_clock),
    .rst_n_i  (rst_n_i),
    .s_valid_i(byte_valid),
    .s_ready_o(byte_ready),
    .s_data_i (byte_data),
    .s_end_i  (byte_end),
    .m_valid_o(raw_tvalid_o),
    .m_ready_i(raw_tready_i),
    .m_last_o (raw_tlast_o),
    .m_data_o (raw_tdata_o)
  );

endmodule

`default_nettype wire

// File: test/acquire_tb.sv
`default_nettype none

module acquire_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SIG_PERIOD  = 100;
  localparam int BUS_PERIOD  = 60;
  localparam int CHUNK       = 16;
  localparam int WORD_BYTES  = 6;
  localparam int MAX_WORDS   = 128;

  localparam int IDLE_WORDS  = 2;
  localparam int CHUNK_WORDS = 6;
  localparam int FRAME_WORDS = 5;
  localparam int STALL_WORDS = 24;
  localparam int BURST_WORDS = 40;
  localparam int FLUSH_WORDS = 2;
  localparam int TOTAL_WORDS = IDLE_WORDS + CHUNK_WORDS + FRAME_WORDS + STALL_WORDS +
                               BURST_WORDS + FLUSH_WORDS;
  localparam int TIMEOUT_NS  = TOTAL_WORDS * WORD_BYTES * 20 * BUS_PERIOD + 16 * SIG_PERIOD;

  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;

  logic        sig_clock;
  logic        bus_clock;
  logic        rst_n_i;
  logic        sig_valid_i;
  logic        sig_last_i;
  logic [23:0] sig_idata_i;
  logic [23:0] sig_qdata_i;
  logic        raw_tvalid_o;
  logic        raw_tready_i;
  logic        raw_tlast_o;
  logic [7:0]  raw_tdata_o;

  logic [47:0] sent_word [MAX_WORDS];  // Q bits above I bits.
  logic        sent_last [MAX_WORDS];
  logic        sent_drop [MAX_WORDS];  // Word may be lost on FIFO overflow.
  int          n_sent      = 0;

  int          word_idx    = 0;
  int          lane_idx    = 0;
  int          pkt_cnt     = 0;
  logic        chk_q       = 1'b0;
  logic        extra_q     = 1'b0;
  logic [7:0]  got_data_q  = '0;
  logic [7:0]  exp_data_q  = '0;
  logic        got_last_q  = 1'b0;
  logic        exp_last_q  = 1'b0;
  logic        stall_q     = 1'b0;
  logic [7:0]  held_data_q = '0;
  logic        held_last_q = 1'b0;

  logic        expect_idle = 1'b1;
  int          ready_mode  = READY_HIGH;
  logic [31:0] data_state  = 32'h4921_6250;
  logic [31:0] ready_state = 32'h4921_6250;

  acquire #(
    .CHUNK      (CHUNK),
    .SRAM_BYTES (64),
    .AFIFO_ABITS(4)
  ) i_acquire (
    .sig_clock   (sig_clock),
    .bus_clock   (bus_clock),
    .rst_n_i     (rst_n_i),
    .sig_valid_i (sig_valid_i),
    .sig_last_i  (sig_last_i),
    .sig_idata_i (sig_idata_i),
    .sig_qdata_i (sig_qdata_i),
    .raw_tvalid_o(raw_tvalid_o),
    .raw_tready_i(raw_tready_i),
    .raw_tlast_o (raw_tlast_o),
    .raw_tdata_o (raw_tdata_o)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] lane_byte(input logic [47:0] word, input int lane);
    return word[lane*8 +: 8];  // Lane 0 is I bits 7..0.
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "Check failed.");
  endtask

  // **************************************************
  // Clocks, output ready and watchdog
  // **************************************************

  initial begin
    sig_clock = 1'b0;
    forever #(SIG_PERIOD / 2) sig_clock = ~sig_clock;
  end

  initial begin
    bus_clock = 1'b0;
    forever #(BUS_PERIOD / 2) bus_clock = ~bus_clock;
  end

  always @(negedge bus_clock) begin
    if (ready_mode == READY_RANDOM) begin
      ready_state = lcg_step(ready_state);
      raw_tready_i = (ready_state[31:30] != 2'b00);  // Ready about three cycles in four.
    end else begin
      raw_tready_i = (ready_mode == READY_HIGH);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the capture path did not deliver every sent word in time.");
    $display("TB FAILED");
    $fatal(1, "Watchdog expired.");
  end

  // **************************************************
  // Scoreboard
  // **************************************************

  always @(posedge bus_clock) begin
    logic last_exp;
    chk_q       <= 1'b0;
    stall_q     <= raw_tvalid_o && !raw_tready_i;
    held_data_q <= raw_tdata_o;
    held_last_q <= raw_tlast_o;
    if (rst_n_i && raw_tvalid_o && raw_tready_i) begin
      if (lane_idx == 0) begin
        while (word_idx < n_sent && sent_drop[word_idx] &&
               sent_word[word_idx][7:0] != raw_tdata_o) begin
          word_idx++;  // Skip words lost on overflow.
        end
      end
      if (word_idx >= n_sent) begin
        extra_q <= 1'b1;
      end else begin
        last_exp = (pkt_cnt == CHUNK - 1) || (lane_idx == WORD_BYTES - 1 && sent_last[word_idx]);
        chk_q      <= 1'b1;
        got_data_q <= raw_tdata_o;
        exp_data_q <= lane_byte(sent_word[word_idx], lane_idx);
        got_last_q <= raw_tlast_o;
        exp_last_q <= last_exp;
        pkt_cnt = last_exp ? 0 : pkt_cnt + 1;
        if (lane_idx == WORD_BYTES - 1) begin
          lane_idx = 0;
          word_idx++;
        end else begin
          lane_idx++;
        end
      end
    end
  end

  // **************************************************
  // Assertions
  // **************************************************

  a_idle: assert property (@(posedge bus_clock) disable iff (!rst_n_i)
    expect_idle |-> (!raw_tvalid_o && !raw_tlast_o))
    else abort_run($sformatf("FAIL raw_tvalid_o %h raw_tlast_o %h before any packet",
                             $sampled(raw_tvalid_o), $sampled(raw_tlast_o)));

  a_data: assert property (@(posedge bus_clock) disable iff (!rst_n_i)
    chk_q |-> (got_data_q == exp_data_q))
    else abort_run($sformatf("FAIL raw_tdata_o got %h expected %h",
                             $sampled(got_data_q), $sampled(exp_data_q)));

  a_last: assert property (@(posedge bus_clock) disable iff (!rst_n_i)
    chk_q |-> (got_last_q == exp_last_q))
    else abort_run($sformatf("FAIL raw_tlast_o got %h expected %h",
                             $sampled(got_last_q), $sampled(exp_last_q)));

  a_extra: assert property (@(posedge bus_clock) disable iff (!rst_n_i) !extra_q)
    else abort_run("The DUT sent a byte for which no word was ever offered.");

  a_hold_valid: assert property (@(posedge bus_clock) disable iff (!rst_n_i)
    stall_q |-> raw_tvalid_o)
    else abort_run($sformatf("FAIL raw_tvalid_o dropped to %h during a stall",
                             $sampled(raw_tvalid_o)));

  a_hold_data: assert property (@(posedge bus_clock) disable iff (!rst_n_i)
    stall_q |-> (raw_tdata_o == held_data_q))
    else abort_run($sformatf("FAIL raw_tdata_o held %h now %h",
                             $sampled(held_data_q), $sampled(raw_tdata_o)));

  a_hold_last: assert property (@(posedge bus_clock) disable iff (!rst_n_i)
    stall_q |-> (raw_tlast_o == held_last_q))
    else abort_run($sformatf("FAIL raw_tlast_o held %h now %h",
                             $sampled(held_last_q), $sampled(raw_tlast_o)));

  // **************************************************
  // Stimulus
  // **************************************************

  // Lane 0 carries the word number so that dropped words can be told apart.
  task automatic offer_word(input logic last, input logic drop_ok, input int gap);
    logic [23:0] i_bits;
    logic [23:0] q_bits;
    data_state = lcg_step(data_state);
    q_bits     = data_state[31:8];
    data_state = lcg_step(data_state);
    i_bits     = {data_state[31:16], n_sent[7:0]};
    sig_valid_i = 1'b1;
    sig_last_i  = last;
    sig_idata_i = i_bits;
    sig_qdata_i = q_bits;
    sent_word[n_sent] = {q_bits, i_bits};
    sent_last[n_sent] = last;
    sent_drop[n_sent] = drop_ok;
    n_sent++;
    @(negedge sig_clock);
    if (gap > 0) begin
      sig_valid_i = 1'b0;
      sig_last_i  = 1'b0;
      repeat (gap) @(negedge sig_clock);
    end
  endtask

  task automatic wait_drain();
    while (word_idx != n_sent) begin
      @(negedge bus_clock);
    end
    @(negedge sig_clock);
  endtask

  initial begin
    logic last;
    rst_n_i      = 1'b0;
    sig_valid_i  = 1'b0;
    sig_last_i   = 1'b0;
    sig_idata_i  = '0;
    sig_qdata_i  = '0;
    raw_tready_i = 1'b1;
    repeat (16) @(negedge sig_clock);
    rst_n_i = 1'b1;
    repeat (10) @(negedge sig_clock);

    // Twelve bytes stay below one chunk, so nothing may leave yet.
    repeat (IDLE_WORDS) offer_word(1'b0, 1'b0, 5);
    repeat (10) @(negedge sig_clock);
    expect_idle = 1'b0;

    repeat (CHUNK_WORDS) offer_word(1'b0, 1'b0, 5);  // Ends on a chunk boundary.

    repeat (3) offer_word(1'b0, 1'b0, 5);
    offer_word(1'b1, 1'b0, 5);  // Packets of 16 and 8 bytes.
    offer_word(1'b1, 1'b0, 5);  // One-word frame.
    wait_drain();

    ready_mode = READY_RANDOM;
    for (int k = 0; k < STALL_WORDS; k++) begin
      data_state = lcg_step(data_state);
      last = (data_state[31:29] == 3'b000) || (k == STALL_WORDS - 1);
      offer_word(last, 1'b0, 8);
    end
    wait_drain();

    ready_mode = READY_LOW;
    @(negedge bus_clock);
    @(negedge sig_clock);
    for (int k = 0; k < BURST_WORDS; k++) begin
      offer_word(1'b0, k != 0, 0);
    end
    sig_valid_i = 1'b0;
    ready_mode  = READY_HIGH;
    repeat (10) @(negedge sig_clock);  // The full FIFO frees room before the flush words.

    offer_word(1'b0, 1'b0, 5);
    offer_word(1'b1, 1'b0, 5);  // Frame end flushes the remaining bytes.
    wait_drain();
    repeat (4) @(posedge bus_clock);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hdl/radio_pkg.sv
hdl/stream_pkg.sv
hdl/axis_afifo.sv
hdl/axis_adapter.sv
hdl/packet_fifo.sv
hdl/acquire.sv
test/acquire_tb.sv
